// ==== logic/spi_cfg.svh ====
// Frame and divider widths shared by the SPI master; SPI_DIV_WIDTH must hold 2^(2^SPI_PRESCALE_BITS) - 1.
`ifndef SPI_CFG_SVH
`define SPI_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Frame format.
////////////////////////////////////////////////////////////////////////////

// Bits shifted out and in per frame.
`define SPI_WORD_LEN 8

////////////////////////////////////////////////////////////////////////////
// Clock prescaler.
////////////////////////////////////////////////////////////////////////////

// Width of the prescale selector. A value p gives a half period of 2^(p+1) cycles.
`define SPI_PRESCALE_BITS 3

// Divider counter width. The largest terminal count is 2^8 - 1 for p = 7.
`define SPI_DIV_WIDTH 9

`endif

// ==== logic/spi_pkg.sv ====
// Types for the SPI master; the transmit request is 14 bits only with the default widths of spi_cfg.svh.
`default_nettype none

`include "spi_cfg.svh"

package spi_pkg;

    // One data word as it travels on mosi and miso.
    typedef logic [`SPI_WORD_LEN-1:0] spi_word_t;

    // Bit 1 is the clock polarity, bit 0 the clock phase.
    // Phase 0 samples on the first edge of a bit, phase 1 on the second.
    typedef logic [1:0] spi_mode_t;

    // Half period of sck is 2^(p+1) cycles of wr.
    typedef logic [`SPI_PRESCALE_BITS-1:0] spi_prescale_t;

    // Everything the shifter needs for one frame, captured with the word.
    typedef struct packed {
        spi_word_t     word;      // Data to shift out.
        spi_mode_t     mode;      // Polarity and phase for this frame.
        logic          lsb_first; // Bit order.
        spi_prescale_t prescale;  // Clock divider selector.
    } spi_tx_req_t;

endpackage

`default_nettype wire

// ==== logic/spi_word_buffer.sv ====
// One-entry holding register; a load while full is dropped and only flagged, and q is valid only while full.
`timescale 1ns/1ps
`default_nettype none

module spi_word_buffer #(
    parameter type payload_t = logic
) (
    input  wire logic wr,
    input  wire logic rst,
    input  wire logic load,      // One-cycle strobe offering a new entry.
    input  payload_t  data,
    input  wire logic take,      // One-cycle strobe that empties the entry.
    input  wire logic err_clr,   // Clears the sticky overrun flag.
    output logic      full,
    output payload_t  q,
    output logic      overrun
);

    logic accept;

    // A load is only taken while the entry is empty.
    assign accept = load && !full;

    ////////////////////////////////////////////////////////////////////////////
    // Control flags.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            full    <= 1'b0;
            overrun <= 1'b0;
        end else begin
            // Once full, only a take empties it. Otherwise an accepted load fills it.
            full <= full ? !take : load;

            // A lost load beats a clear on the same cycle so that no loss goes unseen.
            if (load && full) begin
                overrun <= 1'b1;
            end else if (err_clr) begin
                overrun <= 1'b0;
            end
        end
    end

    // Payload register. It only changes on an accepted load.
    always_ff @(posedge wr) begin
        if (accept) begin
            q <= data; // The stored word stays put until the next accepted load.
        end
    end

endmodule

`default_nettype wire

// ==== logic/spi_clock_gen.sv ====
// Half-period tick generator; prescale must stay stable while clk_run is high, and the count restarts from zero on every run.
`timescale 1ns/1ps
`default_nettype none

`include "spi_cfg.svh"

module spi_clock_gen (
    input  wire logic          wr,
    input  wire logic          rst,
    input  wire logic          clk_run,   // High while a frame is in progress.
    input  spi_pkg::spi_prescale_t prescale,
    output logic               half_tick  // One pulse every 2^(p+1) cycles.
);

    logic [`SPI_PRESCALE_BITS:0]  shift_amt; // One bit wider so that p = 7 gives 8.
    logic [`SPI_DIV_WIDTH-1:0]    div_last;  // Terminal count for the current prescale.
    logic [`SPI_DIV_WIDTH-1:0]    div_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // Terminal count.
    ////////////////////////////////////////////////////////////////////////////

    // The half period is a power of two, so the terminal count is a run of ones.
    assign shift_amt = {1'b0, prescale} + 1'b1;
    assign div_last  = ({{(`SPI_DIV_WIDTH-1){1'b0}}, 1'b1} << shift_amt) - 1'b1;

    // The tick lasts exactly one cycle, on the last count of each half period.
    assign half_tick = clk_run && (div_cnt == div_last);

    ////////////////////////////////////////////////////////////////////////////
    // Divider counter.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (!clk_run) begin
            div_cnt <= '0;                // Held at zero between frames.
        end else if (div_cnt == div_last) begin
            div_cnt <= '0;                // Wrap and start the next half period.
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // With the counter at zero when the run starts, the first tick falls
    // exactly 2^(p+1) cycles after clk_run rises. So does every tick after it.

endmodule

`default_nettype wire

// ==== logic/spi_shifter.sv ====
// Frame FSM and pin driver; tx_req must hold still while tx_pending is high, and miso is taken as already synchronous to wr.
`timescale 1ns/1ps
`default_nettype none

`include "spi_cfg.svh"

module spi_shifter (
    input  wire logic                wr,
    input  wire logic                rst,
    input  wire logic                tx_pending, // Transmit buffer holds a request.
    input  spi_pkg::spi_tx_req_t     tx_req,
    output logic                     tx_take,    // Pulses on the edge a frame starts.
    output logic                     clk_run,
    output spi_pkg::spi_prescale_t   prescale,
    input  wire logic                half_tick,
    output spi_pkg::spi_word_t       rx_word,
    output logic                     rx_strobe,  // Pulses on the edge a frame ends.
    output logic                     sck,
    output logic                     mosi,
    input  wire logic                miso,
    output logic                     ss
);

    import spi_pkg::*;

    // A frame is 2 * WORD_LEN sck edges plus one closing half period.
    localparam int unsigned EDGE_W = $clog2(2 * `SPI_WORD_LEN + 1);
    localparam logic [EDGE_W-1:0] FRAME_EDGES = EDGE_W'(2 * `SPI_WORD_LEN);

    logic              busy;        // FSM state. 0 is idle, 1 is shifting.
    logic [EDGE_W-1:0] edge_cnt;    // Number of sck edges given so far.
    logic              sck_ph;      // Internal clock phase before polarity.
    logic              ss_q;
    logic              mosi_q;
    spi_mode_t         mode_q;      // Mode latched at the start of the frame.
    logic              lsb_q;       // Bit order latched at the start of the frame.
    spi_prescale_t     prescale_q;
    spi_word_t         tx_sr;       // Bits still to go out, next bit at the head.
    spi_word_t         rx_sr;       // Bits gathered from miso.

    logic start;
    logic bit_tick;
    logic frame_done;
    logic sample_edge;

    ////////////////////////////////////////////////////////////////////////////
    // Bit order helpers.
    ////////////////////////////////////////////////////////////////////////////

    // The bit that goes out next, at the top or the bottom of the word.
    function automatic logic head_bit(input spi_word_t w, input logic lsb);
        return lsb ? w[0] : w[`SPI_WORD_LEN-1];
    endfunction

    // Drops the head bit and fills with a one, so mosi idles high once empty.
    function automatic spi_word_t shift_word(input spi_word_t w, input logic lsb);
        spi_word_t r;
        if (lsb) begin
            r = {1'b1, w[`SPI_WORD_LEN-1:1]};
        end else begin
            r = {w[`SPI_WORD_LEN-2:0], 1'b1};
        end
        return r;
    endfunction

    assign start      = !busy && tx_pending;       // Idle and a word is waiting.
    assign bit_tick   = busy && half_tick;
    assign frame_done = (edge_cnt == FRAME_EDGES); // All edges given, this tick closes.

    // Edge k = edge_cnt + 1. Phase 0 samples odd k, phase 1 samples even k.
    assign sample_edge = (edge_cnt[0] == mode_q[0]);

    ////////////////////////////////////////////////////////////////////////////
    // Frame FSM.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            busy       <= 1'b0;
            edge_cnt   <= '0;
            sck_ph     <= 1'b0;
            ss_q       <= 1'b1;  // Device deselected.
            mode_q     <= '0;    // Mode 0, so sck idles low.
            lsb_q      <= 1'b0;
            prescale_q <= '0;
            tx_take    <= 1'b0;
            rx_strobe  <= 1'b0;
        end else begin
            tx_take   <= 1'b0;   // Both strobes last a single cycle.
            rx_strobe <= 1'b0;
            if (start) begin
                // Freeze the frame settings so the user may change them freely.
                busy       <= 1'b1;
                ss_q       <= 1'b0;
                tx_take    <= 1'b1;
                sck_ph     <= 1'b0;
                mode_q     <= tx_req.mode;
                lsb_q      <= tx_req.lsb_first;
                prescale_q <= tx_req.prescale;
            end else if (bit_tick) begin
                if (frame_done) begin
                    busy      <= 1'b0;
                    edge_cnt  <= '0;
                    rx_strobe <= 1'b1;        // rx_sr is complete by now.
                    ss_q      <= !tx_pending; // A waiting word keeps the device selected.
                end else begin
                    sck_ph   <= ~sck_ph;      // Even edge count leaves sck at idle.
                    edge_cnt <= edge_cnt + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Shift registers.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge wr) begin
        if (start) begin
            if (!tx_req.mode[0]) begin
                // Phase 0 needs the first bit valid before the first edge.
                mosi_q <= head_bit(tx_req.word, tx_req.lsb_first);
                tx_sr  <= shift_word(tx_req.word, tx_req.lsb_first);
            end else begin
                tx_sr <= tx_req.word; // Phase 1 drives its first bit on edge 1.
            end
        end else if (bit_tick && !frame_done) begin
            if (sample_edge) begin
                // The first bit in ends at the end of the word it belongs to.
                if (lsb_q) begin
                    rx_sr <= {miso, rx_sr[`SPI_WORD_LEN-1:1]};
                end else begin
                    rx_sr <= {rx_sr[`SPI_WORD_LEN-2:0], miso};
                end
            end else begin
                mosi_q <= head_bit(tx_sr, lsb_q);
                tx_sr  <= shift_word(tx_sr, lsb_q);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Outputs.
    ////////////////////////////////////////////////////////////////////////////

    assign clk_run  = busy;
    assign prescale = prescale_q;

    // No sample edge falls between the frame end and the next start, so rx_sr is stable.
    assign rx_word = rx_sr;

    assign sck  = sck_ph ^ mode_q[1]; // Polarity 1 inverts the internal phase.
    assign mosi = ss_q ? 1'b1 : mosi_q;
    assign ss   = ss_q;

endmodule

`default_nettype wire

// ==== logic/spi_master_top.sv ====
// SPI master top level; all strobes are single cycles on wr with no back-pressure, so check tx_full and rx_ready first.
`timescale 1ns/1ps
`default_nettype none

module spi_master_top (
    input  wire logic              wr,
    input  wire logic              rst,
    input  spi_pkg::spi_mode_t     mode,
    input  wire logic              lsb_first,
    input  spi_pkg::spi_prescale_t prescale,
    input  wire logic              tx_load,
    input  spi_pkg::spi_word_t     tx_data,
    output logic                   tx_full,
    output logic                   send_err,
    input  wire logic              rx_take,
    output spi_pkg::spi_word_t     rx_data,
    output logic                   rx_ready,
    output logic                   rx_overrun,
    input  wire logic              err_clr,
    output logic                   sck,
    output logic                   mosi,
    input  wire logic              miso,
    output logic                   ss
);

    import spi_pkg::*;

    spi_tx_req_t   tx_req_in;   // Word and settings as offered by the user.
    spi_tx_req_t   tx_req_q;    // Request waiting in the transmit buffer.
    logic          tx_take;
    logic          clk_run;
    spi_prescale_t run_prescale;
    logic          half_tick;
    spi_word_t     rx_word;
    logic          rx_strobe;

    ////////////////////////////////////////////////////////////////////////////
    // Transmit side.
    ////////////////////////////////////////////////////////////////////////////

    // The settings travel with the word, so each frame uses its own mode.
    assign tx_req_in = '{word: tx_data, mode: mode, lsb_first: lsb_first, prescale: prescale};

    spi_word_buffer #(
        .payload_t (spi_tx_req_t)
    ) tx_buf_i (
        .wr      (wr),
        .rst     (rst),
        .load    (tx_load),
        .data    (tx_req_in),
        .take    (tx_take),
        .err_clr (err_clr),
        .full    (tx_full),
        .q       (tx_req_q),
        .overrun (send_err)   // A load while full is a send error.
    );

    spi_clock_gen clock_gen_i (
        .wr        (wr),
        .rst       (rst),
        .clk_run   (clk_run),
        .prescale  (run_prescale),
        .half_tick (half_tick)
    );

    spi_shifter shifter_i (
        .wr         (wr),
        .rst        (rst),
        .tx_pending (tx_full),
        .tx_req     (tx_req_q),
        .tx_take    (tx_take),
        .clk_run    (clk_run),
        .prescale   (run_prescale),
        .half_tick  (half_tick),
        .rx_word    (rx_word),
        .rx_strobe  (rx_strobe),
        .sck        (sck),
        .mosi       (mosi),
        .miso       (miso),
        .ss         (ss)
    );

    // Receive side. An unread word is kept and a new one only sets rx_overrun.
    spi_word_buffer #(
        .payload_t (spi_word_t)
    ) rx_buf_i (
        .wr      (wr),
        .rst     (rst),
        .load    (rx_strobe),
        .data    (rx_word),
        .take    (rx_take),
        .err_clr (err_clr),
        .full    (rx_ready),
        .q       (rx_data),
        .overrun (rx_overrun)
    );

endmodule

`default_nettype wire

// ==== tests/spi_slave_model.sv ====
// Behavioural SPI device sampled on wr; mode and lsb_first must match the frame in flight, and the reply is ~ the previous word.
`timescale 1ns/1ps
`default_nettype none

`include "spi_cfg.svh"

module spi_slave_model (
    input  wire logic                          wr,
    input  wire logic                          rst,
    input  wire logic                          sck,
    input  wire logic                          mosi,
    input  wire logic                          ss,
    input  wire logic [1:0]                    mode,       // Bit 0 is the clock phase.
    input  wire logic                          lsb_first,
    output logic                               miso,
    output logic [`SPI_WORD_LEN-1:0]           captured    // Last complete word from mosi.
);

    localparam int N = `SPI_WORD_LEN;

    logic         sck_d;
    logic         ss_d;
    int           k;          // Edge number within the current frame.
    logic [N-1:0] cap;        // Word being gathered from mosi.
    logic [N-1:0] reply;      // Word being returned on miso.

    // Wire position of bit j in the selected bit order.
    function automatic int bit_pos(input int j, input logic lsb);
        return lsb ? j : N - 1 - j;
    endfunction

    always @(posedge wr or posedge rst) begin
        if (rst) begin
            sck_d    <= 1'b0;
            ss_d     <= 1'b1;
            k         = 0;
            cap       = '0;
            reply     = '0;           // The first frame returns zero.
            miso     <= 1'b1;
            captured <= '0;
        end else begin
            if (!ss && ss_d) begin
                k = 0;                // Device just selected.
                if (!mode[0]) miso <= reply[bit_pos(0, lsb_first)]; // Phase 0 bit leads.
            end else if (!ss && !ss_d && (sck != sck_d)) begin
                k = k + 1;
                if ((k % 2 == 1) == !mode[0]) begin
                    // Sample edge. Phase 0 samples odd edges, phase 1 even ones.
                    cap[bit_pos(mode[0] ? k / 2 - 1 : (k - 1) / 2, lsb_first)] = mosi;
                end else if (mode[0]) begin
                    miso <= reply[bit_pos((k - 1) / 2, lsb_first)];
                end else if (k < 2 * N) begin
                    miso <= reply[bit_pos(k / 2, lsb_first)];
                end
                if (k == 2 * N) begin
                    captured <= cap;  // Frame complete.
                    reply     = ~cap;
                    k         = 0;
                    // A back-to-back frame in phase 0 needs its first bit ready now.
                    if (!mode[0]) miso <= reply[bit_pos(0, lsb_first)];
                end
            end
            sck_d <= sck;
            ss_d  <= ss;
        end
    end

endmodule

`default_nettype wire

// ==== tests/spi_master_asserts.sv ====
// Bound to spi_master_top; edges are seen one wr cycle late and prescale must hold for a frame.
`timescale 1ns/1ps
`default_nettype none

`include "spi_cfg.svh"

module spi_master_asserts (
    input  wire logic              wr,
    input  wire logic              rst,
    input  wire logic              sck,
    input  wire logic              mosi,
    input  wire logic              ss,
    input  wire logic              tx_full,
    input  wire logic              send_err,
    input  wire logic              rx_ready,
    input  wire logic              rx_overrun,
    input  spi_pkg::spi_prescale_t prescale     // Prescale the user selected for the frame.
);

    localparam logic [7:0] EDGES = 8'(2 * `SPI_WORD_LEN);

    logic       sck_d;
    logic       ss_d;
    logic       sck_edge;
    logic [9:0] gap;          // Cycles since the last sck edge was seen.
    logic [7:0] sel_edges;    // Edges seen since ss fell.
    logic [9:0] half_period;
    int         fail_cnt;     // Number of assertion failures so far.

    initial fail_cnt = 0;

    // Only edges with ss low on both sides count, so mode changes at a start are ignored.
    assign sck_edge    = (sck != sck_d) && !ss && !ss_d;
    assign half_period = 10'd2 << prescale;

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            sck_d     <= 1'b0;
            ss_d      <= 1'b1;
            gap       <= '0;
            sel_edges <= '0;
        end else begin
            sck_d     <= sck;
            ss_d      <= ss;
            gap       <= sck_edge ? 10'd1 : gap + 10'd1;
            sel_edges <= ss ? 8'd0 : sel_edges + {7'd0, sck_edge};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Properties.
    ////////////////////////////////////////////////////////////////////////////

    a_reset_state: assert property (@(posedge wr)
        rst |-> ss && !tx_full && !send_err && !rx_ready && !rx_overrun)
        else begin
            $error("Reset left a pin or flag active");
            fail_cnt++;
        end

    a_idle_mosi: assert property (@(posedge wr) disable iff (rst) ss |-> mosi)
        else begin
            $error("mosi low while ss high");
            fail_cnt++;
        end

    a_idle_sck: assert property (@(posedge wr) disable iff (rst) ss && ss_d |-> sck == sck_d)
        else begin
            $error("sck moved while ss high");
            fail_cnt++;
        end

    // The first edge of each frame is not checked. Its gap includes the idle time.
    a_edge_gap: assert property (@(posedge wr) disable iff (rst)
        sck_edge && (sel_edges % EDGES != 0) |-> gap == half_period)
        else begin
            $error("sck half period wrong");
            fail_cnt++;
        end

    a_frame_edges: assert property (@(posedge wr) disable iff (rst)
        $rose(ss) |-> sel_edges != 0 && sel_edges % EDGES == 0)
        else begin
            $error("Frame edge count wrong");
            fail_cnt++;
        end

endmodule

bind spi_master_top spi_master_asserts asserts_i (
    .wr         (wr),
    .rst        (rst),
    .sck        (sck),
    .mosi       (mosi),
    .ss         (ss),
    .tx_full    (tx_full),
    .send_err   (send_err),
    .rx_ready   (rx_ready),
    .rx_overrun (rx_overrun),
    .prescale   (prescale)
);

`default_nettype wire

// ==== tests/spi_master_tb.sv ====
// Testbench for spi_master_top; mode, bit order and prescale stay fixed for each whole frame.
`timescale 1ns/1ps
`default_nettype none

`include "spi_cfg.svh"

module spi_master_tb;

    import spi_pkg::*;

    localparam int N = `SPI_WORD_LEN;

    // Frame length in cycles for prescale p, with the two cycles of buffer latency.
    function automatic int frame_cycles(input int p);
        return (2 * N + 1) * (2 << p) + 2;
    endfunction

    // Sixteen mode frames, then five frames at prescale 1, with margin.
    localparam int LIMIT = (3 * (8 * frame_cycles(0) + 8 * frame_cycles(2)
                                 + 5 * frame_cycles(1) + 16)) / 2;

    logic          wr, rst, lsb_first, tx_load, rx_take, err_clr;
    spi_mode_t     mode;
    spi_prescale_t prescale;
    spi_word_t     tx_data, rx_data, slave_word, exp_reply, word_a, word_b;
    logic          tx_full, send_err, rx_ready, rx_overrun, sck, mosi, miso, ss;
    int            errors, checks, cycle_cnt, ss_rises, rises_before;
    integer        seed;

    spi_master_top spi_master_top_i (
        .wr (wr), .rst (rst), .mode (mode), .lsb_first (lsb_first), .prescale (prescale),
        .tx_load (tx_load), .tx_data (tx_data), .tx_full (tx_full), .send_err (send_err),
        .rx_take (rx_take), .rx_data (rx_data), .rx_ready (rx_ready),
        .rx_overrun (rx_overrun), .err_clr (err_clr),
        .sck (sck), .mosi (mosi), .miso (miso), .ss (ss)
    );

    spi_slave_model slave_i (
        .wr (wr), .rst (rst), .sck (sck), .mosi (mosi), .ss (ss), .mode (mode),
        .lsb_first (lsb_first), .miso (miso), .captured (slave_word)
    );

    always #20 wr = ~wr;    // 40 ns period.

    always @(posedge ss) ss_rises++;

    // Watchdog on the total cycle budget.
    always @(posedge wr) begin
        cycle_cnt++;
        if (cycle_cnt >= LIMIT) begin
            $display("Timeout: the DUT did not finish within %0d cycles", LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic expect_true(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("Error at %0t: %s", $time, msg);
        end
    endtask

    task automatic pulse(ref logic sig);
        @(negedge wr);
        sig = 1'b1;
        @(negedge wr);
        sig = 1'b0;
    endtask

    task automatic load_word(input spi_word_t w);
        tx_data = w;
        pulse(tx_load);
    endtask

    task automatic wait_rx_ready();
        while (!rx_ready) @(negedge wr);
    endtask

    // Checks the slave's copy and the reply, then frees the receive buffer.
    task automatic check_frame(input spi_word_t w);
        expect_true(slave_word == w, $sformatf("slave got %h, sent %h", slave_word, w));
        expect_true(rx_data == exp_reply, $sformatf("rx %h, expected %h", rx_data, exp_reply));
        exp_reply = ~w;                   // The slave answers with the inverse next.
        pulse(rx_take);
    endtask

    task automatic send_and_check(input spi_word_t w);
        load_word(w);
        wait_rx_ready();
        check_frame(w);
        expect_true(ss && mosi && (sck == mode[1]), "idle pins wrong after frame");
    endtask

    initial begin
        seed = 32'hc752;
        wr = 1'b0;
        rst = 1'b1;
        mode = '0;
        lsb_first = 1'b0;
        prescale = '0;
        tx_load = 1'b0;
        tx_data = '0;
        rx_take = 1'b0;
        err_clr = 1'b0;
        errors = 0;
        checks = 0;
        cycle_cnt = 0;
        ss_rises = 0;
        exp_reply = '0;
        repeat (16) @(negedge wr);
        rst = 1'b0;

        ///////////////////////////////////////////////////////////////////////////
        // All modes, both bit orders, prescale 0 and 2.
        ///////////////////////////////////////////////////////////////////////////
        for (int m = 0; m < 4; m++) begin
            for (int l = 0; l < 2; l++) begin
                for (int p = 0; p <= 2; p += 2) begin
                    @(negedge wr);
                    mode = m[1:0];
                    lsb_first = l[0];
                    prescale = p[`SPI_PRESCALE_BITS-1:0];
                    send_and_check(spi_word_t'($random(seed)));
                end
            end
        end

        // Send error. The second load lands while the first word still waits.
        mode = 2'd1;
        lsb_first = 1'b1;
        prescale = 3'd1;
        word_a = spi_word_t'($random(seed));
        word_b = spi_word_t'($random(seed));
        load_word(word_a);
        expect_true(tx_full, "tx_full not set after load");
        tx_data = word_b;
        tx_load = 1'b1;
        @(negedge wr);
        tx_load = 1'b0;
        expect_true(send_err, "send_err not raised by load while full");
        wait_rx_ready();
        check_frame(word_a);
        pulse(err_clr);
        expect_true(!send_err && !tx_full, "send_err not cleared or stray word sent");

        // Back-to-back words keep ss low.
        word_a = spi_word_t'($random(seed));
        word_b = spi_word_t'($random(seed));
        load_word(word_a);
        while (tx_full) @(negedge wr);
        rises_before = ss_rises;
        load_word(word_b);
        wait_rx_ready();
        expect_true(!ss, "ss high between back-to-back words");
        check_frame(word_a);
        wait_rx_ready();
        check_frame(word_b);
        expect_true(ss_rises == rises_before + 1, "ss rose inside back-to-back frames");

        // Receive overrun keeps the first word.
        word_a = spi_word_t'($random(seed));
        word_b = spi_word_t'($random(seed));
        load_word(word_a);
        wait_rx_ready();
        load_word(word_b);
        while (!rx_overrun) @(negedge wr);
        expect_true(slave_word == word_b, "second overrun word not sent");
        expect_true(rx_data == exp_reply, "rx_data lost the first word on overrun");
        exp_reply = ~word_b;
        pulse(rx_take);
        pulse(err_clr);
        expect_true(!rx_ready && !rx_overrun, "receive flags not cleared");

        repeat (4) @(negedge wr);
        errors = errors + spi_master_top_i.asserts_i.fail_cnt;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, spi_master_top_i.asserts_i.fail_cnt);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== spi_link.f ====
+incdir+logic
logic/spi_pkg.sv
logic/spi_word_buffer.sv
logic/spi_clock_gen.sv
logic/spi_shifter.sv
logic/spi_master_top.sv
tests/spi_slave_model.sv
tests/spi_master_asserts.sv
tests/spi_master_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the SPI master testbench with Verilator, runs it and checks the result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module spi_master_tb \
    -f spi_link.f \
    -o spi_master_sim

# The simulator keeps running after an assertion error so that the testbench can report.
out=$(./obj_dir/spi_master_sim +verilator+error+limit+1000 || true)
echo "$out"

if grep -q "TESTS PASSED" <<< "$out"; then
    exit 0
else
    exit 1
fi
